// ==== verilog/csr_arch_pkg.sv ====
`default_nettype none

package csr_arch_pkg;

    localparam int XLEN = 32;

    typedef logic [11:0] csr_addr_t;

    // user counters, time aliases cycle
    localparam csr_addr_t CSR_ADDR_CYCLE     = 12'hc00;
    localparam csr_addr_t CSR_ADDR_TIME      = 12'hc01;
    localparam csr_addr_t CSR_ADDR_INSTRET   = 12'hc02;
    localparam csr_addr_t CSR_ADDR_CYCLEH    = 12'hc80;
    localparam csr_addr_t CSR_ADDR_TIMEH     = 12'hc81;
    localparam csr_addr_t CSR_ADDR_INSTRETH  = 12'hc82;

    localparam csr_addr_t CSR_ADDR_MVENDORID = 12'hf11;
    localparam csr_addr_t CSR_ADDR_MARCHID   = 12'hf12;
    localparam csr_addr_t CSR_ADDR_MIMPID    = 12'hf13;
    localparam csr_addr_t CSR_ADDR_MHARTID   = 12'hf14;

    localparam csr_addr_t CSR_ADDR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_ADDR_MISA      = 12'h301;
    localparam csr_addr_t CSR_ADDR_MEDELEG   = 12'h302;
    localparam csr_addr_t CSR_ADDR_MIDELEG   = 12'h303;
    localparam csr_addr_t CSR_ADDR_MIE       = 12'h304;
    localparam csr_addr_t CSR_ADDR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_ADDR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_ADDR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_ADDR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_ADDR_MTVAL     = 12'h343;
    localparam csr_addr_t CSR_ADDR_MIP       = 12'h344;

    localparam csr_addr_t CSR_ADDR_MCYCLE    = 12'hb00;
    localparam csr_addr_t CSR_ADDR_MINSTRET  = 12'hb02;
    localparam csr_addr_t CSR_ADDR_MCYCLEH   = 12'hb80;
    localparam csr_addr_t CSR_ADDR_MINSTRETH = 12'hb82;

    // non-standard compare register, custom machine rw space
    localparam csr_addr_t CSR_ADDR_MTIMECMP  = 12'h7c0;
    localparam csr_addr_t CSR_ADDR_MTIMECMPH = 12'h7c1;

    typedef enum logic [2:0] {
        F3_CSRRW  = 3'b001,
        F3_CSRRS  = 3'b010,
        F3_CSRRC  = 3'b011,
        F3_CSRRWI = 3'b101,
        F3_CSRRSI = 3'b110,
        F3_CSRRCI = 3'b111
    } csr_funct3_e;

    typedef enum logic [1:0] {
        CSR_OP_NONE,
        CSR_OP_WRITE,
        CSR_OP_SET,
        CSR_OP_CLEAR
    } csr_op_e;

    // m-mode only, everything but mie/mpie reads zero
    typedef struct packed {
        logic [23:0] rsvd_hi;
        logic        mpie;      // bit 7
        logic [2:0]  rsvd_mid;
        logic        mie;       // bit 3
        logic [2:0]  rsvd_lo;
    } mstatus_t;

    typedef struct packed {
        logic [19:0] rsvd_hi;
        logic        meip;      // bit 11
        logic [2:0]  rsvd_2;
        logic        mtip;      // bit 7
        logic [2:0]  rsvd_1;
        logic        msip;      // bit 3
        logic [2:0]  rsvd_0;
    } mip_t;

    typedef struct packed {
        logic [19:0] rsvd_hi;
        logic        meie;
        logic [2:0]  rsvd_2;
        logic        mtie;
        logic [2:0]  rsvd_1;
        logic        msie;
        logic [2:0]  rsvd_0;
    } mie_t;

    localparam logic [XLEN-1:0] CAUSE_MSI = 32'h8000_0003;
    localparam logic [XLEN-1:0] CAUSE_MTI = 32'h8000_0007;
    localparam logic [XLEN-1:0] CAUSE_MEI = 32'h8000_000b;

    localparam logic [XLEN-1:0] MISA_RV32I = 32'h4000_0100;   // mxl=1, i bit

endpackage

`default_nettype wire

// ==== verilog/csr_port_pkg.sv ====
`default_nettype none

package csr_port_pkg;

    localparam int INST_IDX_W = 4;

    typedef struct packed {
        csr_arch_pkg::csr_addr_t csr;
        logic [4:0]              rs1;
        logic [2:0]              funct3;
        logic [4:0]              rd;
        logic [6:0]              opcode;
    } csr_inst_reg_t;

    typedef struct packed {
        csr_arch_pkg::csr_addr_t csr;
        logic [4:0]              uimm;     // zero-extended by the decoder
        logic [2:0]              funct3;
        logic [4:0]              rd;
        logic [6:0]              opcode;
    } csr_inst_imm_t;

    // funct3[2] tells which view is live
    typedef union packed {
        csr_inst_reg_t reg_view;
        csr_inst_imm_t imm_view;
    } csr_inst_u;

    typedef struct packed {
        logic                              vld;
        logic                              rd_en;
        csr_arch_pkg::csr_addr_t           addr;
        csr_arch_pkg::csr_op_e             op;
        logic [csr_arch_pkg::XLEN-1:0]     operand;
        logic [4:0]                        rd;
        logic [INST_IDX_W-1:0]             inst_idx;
    } csr_req_t;

    typedef struct packed {
        logic                              en;
        csr_arch_pkg::csr_addr_t           addr;
        logic [csr_arch_pkg::XLEN-1:0]     data;
    } csr_wr_t;

    typedef struct packed {
        logic                              vld;
        logic [csr_arch_pkg::XLEN-1:0]     pc;
        logic [csr_arch_pkg::XLEN-1:0]     cause;
        logic [csr_arch_pkg::XLEN-1:0]     tval;
    } trap_t;

    typedef struct packed {
        csr_arch_pkg::mstatus_t            mstatus;
        logic [csr_arch_pkg::XLEN-1:0]     mtvec;
        logic [csr_arch_pkg::XLEN-1:0]     mepc;
        logic [csr_arch_pkg::XLEN-1:0]     mcause;
        logic [csr_arch_pkg::XLEN-1:0]     mtval;
        logic [csr_arch_pkg::XLEN-1:0]     mscratch;
    } trap_state_t;

    typedef struct packed {
        logic                              wr_en;
        logic [4:0]                        index;
        logic [csr_arch_pkg::XLEN-1:0]     val;
        logic [INST_IDX_W-1:0]             inst_idx;
        logic                              commit;
    } reg_wb_t;

endpackage

`default_nettype wire

// ==== verilog/csr_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_decode (
    input  logic                                   instruction_vld,
    input  csr_port_pkg::csr_inst_u                instruction_pld,
    input  logic [csr_port_pkg::INST_IDX_W-1:0]    instruction_idx,
    input  logic                                   inst_rd_en,
    input  logic [csr_arch_pkg::XLEN-1:0]          rs1_val,
    output csr_port_pkg::csr_req_t                 req
);

    logic [2:0] funct3;

    assign funct3 = instruction_pld.reg_view.funct3;

    always_comb begin
        req          = '0;
        req.vld      = instruction_vld;
        req.rd_en    = inst_rd_en;
        req.addr     = instruction_pld.reg_view.csr;
        req.rd       = instruction_pld.reg_view.rd;
        req.inst_idx = instruction_idx;

        case (funct3)
            csr_arch_pkg::F3_CSRRW, csr_arch_pkg::F3_CSRRWI: req.op = csr_arch_pkg::CSR_OP_WRITE;
            csr_arch_pkg::F3_CSRRS, csr_arch_pkg::F3_CSRRSI: req.op = csr_arch_pkg::CSR_OP_SET;
            csr_arch_pkg::F3_CSRRC, csr_arch_pkg::F3_CSRRCI: req.op = csr_arch_pkg::CSR_OP_CLEAR;
            default:                                         req.op = csr_arch_pkg::CSR_OP_NONE;
        endcase

        // immediate forms carry uimm in the rs1 slot
        if (funct3[2])
            req.operand = {{(csr_arch_pkg::XLEN-5){1'b0}}, instruction_pld.imm_view.uimm};
        else
            req.operand = rs1_val;
    end

endmodule

`default_nettype wire

// ==== verilog/csr_trap_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_trap_regs #(
    parameter logic [csr_arch_pkg::XLEN-1:0] MSCRATCH_RESET = '0
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  csr_port_pkg::csr_wr_t       wr,
    input  csr_port_pkg::trap_t         trap,
    input  logic                        mret_en,
    output csr_port_pkg::trap_state_t   state
);

    logic                            mie_q;
    logic                            mpie_q;
    logic [csr_arch_pkg::XLEN-1:0]   mtvec_q;
    logic [csr_arch_pkg::XLEN-1:0]   mepc_q;
    logic [csr_arch_pkg::XLEN-1:0]   mcause_q;
    logic [csr_arch_pkg::XLEN-1:0]   mtval_q;
    logic [csr_arch_pkg::XLEN-1:0]   mscratch_q;
    csr_arch_pkg::mstatus_t          wr_status;

    logic wr_mstatus;
    logic wr_mtvec;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_mtval;
    logic wr_mscratch;

    assign wr_status   = wr.data;
    assign wr_mstatus  = wr.en && (wr.addr == csr_arch_pkg::CSR_ADDR_MSTATUS);
    assign wr_mtvec    = wr.en && (wr.addr == csr_arch_pkg::CSR_ADDR_MTVEC);
    assign wr_mepc     = wr.en && (wr.addr == csr_arch_pkg::CSR_ADDR_MEPC);
    assign wr_mcause   = wr.en && (wr.addr == csr_arch_pkg::CSR_ADDR_MCAUSE);
    assign wr_mtval    = wr.en && (wr.addr == csr_arch_pkg::CSR_ADDR_MTVAL);
    assign wr_mscratch = wr.en && (wr.addr == csr_arch_pkg::CSR_ADDR_MSCRATCH);

    // trap beats mret beats a csr write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_q  <= 1'b0;
            mpie_q <= 1'b0;
        end else if (trap.vld) begin
            mpie_q <= mie_q;
            mie_q  <= 1'b0;            // handler runs with interrupts off
        end else if (mret_en) begin
            mie_q  <= mpie_q;
            mpie_q <= 1'b1;
        end else if (wr_mstatus) begin
            mie_q  <= wr_status.mie;
            mpie_q <= wr_status.mpie;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_q <= '0;
        end else if (wr_mtvec) begin
            mtvec_q[csr_arch_pkg::XLEN-1:2] <= wr.data[csr_arch_pkg::XLEN-1:2];
            if (!wr.data[1])
                mtvec_q[1:0] <= wr.data[1:0];   // only direct/vectored are legal
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc_q   <= '0;
            mcause_q <= '0;
            mtval_q  <= '0;
        end else if (trap.vld) begin
            mepc_q   <= trap.pc;
            mcause_q <= trap.cause;
            mtval_q  <= trap.cause[csr_arch_pkg::XLEN-1] ? '0 : trap.tval;
        end else begin
            if (wr_mepc)
                mepc_q <= wr.data;
            if (wr_mcause)
                mcause_q <= wr.data;
            if (wr_mtval)
                mtval_q <= wr.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            mscratch_q <= MSCRATCH_RESET;
        else if (wr_mscratch)
            mscratch_q <= wr.data;
    end

    always_comb begin
        state              = '0;
        state.mstatus.mie  = mie_q;
        state.mstatus.mpie = mpie_q;
        state.mtvec        = mtvec_q;
        state.mepc         = mepc_q;
        state.mcause       = mcause_q;
        state.mtval        = mtval_q;
        state.mscratch     = mscratch_q;
    end

endmodule

`default_nettype wire

// ==== verilog/csr_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_timer #(
    parameter logic [63:0] MTIMECMP_RESET = 64'h0000_0000_8000_0000
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  csr_port_pkg::csr_wr_t   wr,
    output logic [63:0]             cycle,
    output logic [63:0]             mtimecmp,
    output logic                    mtip
);

    logic wr_lo;
    logic wr_hi;

    assign wr_lo = wr.en && (wr.addr == csr_arch_pkg::CSR_ADDR_MTIMECMP);
    assign wr_hi = wr.en && (wr.addr == csr_arch_pkg::CSR_ADDR_MTIMECMPH);

    // free running, also read back as time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cycle <= '0;
        else
            cycle <= cycle + 64'd1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp <= MTIMECMP_RESET;
        end else begin
            if (wr_lo)
                mtimecmp[31:0] <= wr.data;
            if (wr_hi)
                mtimecmp[63:32] <= wr.data;
        end
    end

    assign mtip = (cycle > mtimecmp);   // strictly past the compare value

endmodule

`default_nettype wire

// ==== verilog/csr_intr_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_intr_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,
    input  csr_port_pkg::csr_wr_t           wr,
    input  csr_arch_pkg::mstatus_t          mstatus,
    input  logic                            mtip,
    input  logic                            intr_meip_sync,
    input  logic                            intr_msip_sync,
    input  logic                            intr_rdy,
    output logic                            intr_vld,
    output logic [csr_arch_pkg::XLEN-1:0]   intr_op,
    output csr_arch_pkg::mip_t              mip,
    output csr_arch_pkg::mie_t              mie
);

    logic                 meip_q;
    logic                 msip_q;
    logic                 mtip_q;
    logic                 meie_q;
    logic                 msie_q;
    logic                 mtie_q;
    csr_arch_pkg::mip_t   wr_val;     // same bit positions serve mip and mie
    logic                 wr_mip;
    logic                 wr_mie;
    logic                 me_en;
    logic                 ms_en;
    logic                 mt_en;
    logic                 handshake;

    assign wr_val = wr.data;
    assign wr_mip = wr.en && (wr.addr == csr_arch_pkg::CSR_ADDR_MIP);
    assign wr_mie = wr.en && (wr.addr == csr_arch_pkg::CSR_ADDR_MIE);

    // one pending source at a time, meip first
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meip_q <= 1'b0;
            msip_q <= 1'b0;
            mtip_q <= 1'b0;
        end else if (handshake) begin
            meip_q <= 1'b0;
            msip_q <= 1'b0;
            mtip_q <= 1'b0;
        end else if (intr_meip_sync || intr_msip_sync || mtip) begin
            meip_q <= intr_meip_sync;
            msip_q <= intr_msip_sync && !intr_meip_sync;
            mtip_q <= mtip && !intr_msip_sync && !intr_meip_sync;
        end else if (wr_mip) begin
            meip_q <= wr_val.meip;
            msip_q <= wr_val.msip;
            mtip_q <= wr_val.mtip;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meie_q <= 1'b1;     // external enabled out of reset
            msie_q <= 1'b0;
            mtie_q <= 1'b0;
        end else if (wr_mie) begin
            meie_q <= wr_val.meip;
            msie_q <= wr_val.msip;
            mtie_q <= wr_val.mtip;
        end
    end

    always_comb begin
        mip      = '0;
        mip.meip = meip_q;
        mip.msip = msip_q;
        mip.mtip = mtip_q;
        mie      = '0;
        mie.meie = meie_q;
        mie.msie = msie_q;
        mie.mtie = mtie_q;
    end

    assign me_en = mstatus.mie && meie_q && meip_q;
    assign ms_en = mstatus.mie && msie_q && msip_q;
    assign mt_en = mstatus.mie && mtie_q && mtip_q;

    assign intr_vld  = me_en || ms_en || mt_en;
    assign intr_op   = me_en ? csr_arch_pkg::CAUSE_MEI :
                       ms_en ? csr_arch_pkg::CAUSE_MSI :
                       mt_en ? csr_arch_pkg::CAUSE_MTI : '0;
    assign handshake = intr_vld && intr_rdy;

endmodule

`default_nettype wire

// ==== verilog/csr_rmw.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_rmw #(
    parameter logic [csr_arch_pkg::XLEN-1:0] HART_ID = '0
) (
    input  csr_port_pkg::csr_req_t          req,
    input  csr_port_pkg::trap_state_t       state,
    input  logic [63:0]                     cycle,
    input  logic [63:0]                     mtimecmp,
    input  csr_arch_pkg::mip_t              mip,
    input  csr_arch_pkg::mie_t              mie,
    output csr_port_pkg::csr_wr_t           wr,
    output csr_port_pkg::reg_wb_t           reg_wb
);

    logic [csr_arch_pkg::XLEN-1:0] rdata;
    logic [csr_arch_pkg::XLEN-1:0] wdata;
    logic                          wr_en;

    always_comb begin
        case (req.addr)
            csr_arch_pkg::CSR_ADDR_CYCLE,
            csr_arch_pkg::CSR_ADDR_TIME,
            csr_arch_pkg::CSR_ADDR_MCYCLE:    rdata = cycle[31:0];
            csr_arch_pkg::CSR_ADDR_CYCLEH,
            csr_arch_pkg::CSR_ADDR_TIMEH,
            csr_arch_pkg::CSR_ADDR_MCYCLEH:   rdata = cycle[63:32];
            csr_arch_pkg::CSR_ADDR_MTIMECMP:  rdata = mtimecmp[31:0];
            csr_arch_pkg::CSR_ADDR_MTIMECMPH: rdata = mtimecmp[63:32];
            csr_arch_pkg::CSR_ADDR_MHARTID:   rdata = HART_ID;
            csr_arch_pkg::CSR_ADDR_MISA:      rdata = csr_arch_pkg::MISA_RV32I;
            csr_arch_pkg::CSR_ADDR_MSTATUS:   rdata = state.mstatus;
            csr_arch_pkg::CSR_ADDR_MTVEC:     rdata = state.mtvec;
            csr_arch_pkg::CSR_ADDR_MEPC:      rdata = state.mepc;
            csr_arch_pkg::CSR_ADDR_MCAUSE:    rdata = state.mcause;
            csr_arch_pkg::CSR_ADDR_MTVAL:     rdata = state.mtval;
            csr_arch_pkg::CSR_ADDR_MSCRATCH:  rdata = state.mscratch;
            csr_arch_pkg::CSR_ADDR_MIP:       rdata = mip;
            csr_arch_pkg::CSR_ADDR_MIE:       rdata = mie;
            // no instret, no ids, no delegation
            csr_arch_pkg::CSR_ADDR_INSTRET,
            csr_arch_pkg::CSR_ADDR_INSTRETH,
            csr_arch_pkg::CSR_ADDR_MINSTRET,
            csr_arch_pkg::CSR_ADDR_MINSTRETH,
            csr_arch_pkg::CSR_ADDR_MVENDORID,
            csr_arch_pkg::CSR_ADDR_MARCHID,
            csr_arch_pkg::CSR_ADDR_MIMPID,
            csr_arch_pkg::CSR_ADDR_MEDELEG,
            csr_arch_pkg::CSR_ADDR_MIDELEG:   rdata = '0;
            default:                          rdata = '0;
        endcase
    end

    always_comb begin
        case (req.op)
            csr_arch_pkg::CSR_OP_WRITE: wdata = req.operand;
            csr_arch_pkg::CSR_OP_SET:   wdata = rdata | req.operand;
            csr_arch_pkg::CSR_OP_CLEAR: wdata = rdata & ~req.operand;
            default:                    wdata = '0;     // bad funct3 still writes
        endcase
    end

    // rd_en gates the csr write as well as the writeback
    assign wr_en = req.vld && req.rd_en;

    assign wr.en   = wr_en;
    assign wr.addr = req.addr;
    assign wr.data = wdata;

    assign reg_wb.wr_en    = wr_en;
    assign reg_wb.index    = req.rd;
    assign reg_wb.val      = rdata;     // old value goes back to rd
    assign reg_wb.inst_idx = req.inst_idx;
    assign reg_wb.commit   = req.vld;

endmodule

`default_nettype wire

// ==== verilog/csr_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_unit #(
    parameter logic [csr_arch_pkg::XLEN-1:0] HART_ID        = 32'd1,
    parameter logic [63:0]                   MTIMECMP_RESET = 64'h0000_0000_8000_0000,
    parameter logic [csr_arch_pkg::XLEN-1:0] MSCRATCH_RESET = 32'hb000_0000
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   instruction_vld,
    input  csr_port_pkg::csr_inst_u                instruction_pld,
    input  logic [csr_port_pkg::INST_IDX_W-1:0]    instruction_idx,
    input  logic                                   inst_rd_en,
    input  logic [csr_arch_pkg::XLEN-1:0]          rs1_val,
    input  csr_port_pkg::trap_t                    trap,
    input  logic                                   mret_en,
    input  logic                                   intr_meip_sync,
    input  logic                                   intr_msip_sync,
    input  logic                                   intr_rdy,
    output logic                                   intr_vld,
    output logic [csr_arch_pkg::XLEN-1:0]          intr_op,
    output csr_port_pkg::reg_wb_t                  reg_wb,
    output logic [csr_arch_pkg::XLEN-1:0]          csr_mtvec_val,
    output logic [csr_arch_pkg::XLEN-1:0]          csr_mepc_val
);

    csr_port_pkg::csr_req_t       req;
    csr_port_pkg::csr_wr_t        wr;
    csr_port_pkg::trap_state_t    state;
    logic [63:0]                  cycle;
    logic [63:0]                  mtimecmp;
    logic                         mtip;
    csr_arch_pkg::mip_t           mip;
    csr_arch_pkg::mie_t           mie;

    csr_decode u_decode (
        .instruction_vld (instruction_vld),
        .instruction_pld (instruction_pld),
        .instruction_idx (instruction_idx),
        .inst_rd_en      (inst_rd_en),
        .rs1_val         (rs1_val),
        .req             (req)
    );

    csr_rmw #(.HART_ID(HART_ID)) u_rmw (
        .req      (req),
        .state    (state),
        .cycle    (cycle),
        .mtimecmp (mtimecmp),
        .mip      (mip),
        .mie      (mie),
        .wr       (wr),
        .reg_wb   (reg_wb)
    );

    csr_trap_regs #(.MSCRATCH_RESET(MSCRATCH_RESET)) u_trap_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (wr),
        .trap    (trap),
        .mret_en (mret_en),
        .state   (state)
    );

    csr_timer #(.MTIMECMP_RESET(MTIMECMP_RESET)) u_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr       (wr),
        .cycle    (cycle),
        .mtimecmp (mtimecmp),
        .mtip     (mtip)
    );

    csr_intr_ctrl u_intr_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr             (wr),
        .mstatus        (state.mstatus),
        .mtip           (mtip),
        .intr_meip_sync (intr_meip_sync),
        .intr_msip_sync (intr_msip_sync),
        .intr_rdy       (intr_rdy),
        .intr_vld       (intr_vld),
        .intr_op        (intr_op),
        .mip            (mip),
        .mie            (mie)
    );

    // trap vector and return address for the fetch unit
    assign csr_mtvec_val = state.mtvec;
    assign csr_mepc_val  = state.mepc;

endmodule

`default_nettype wire

// ==== dv/csr_model.svh ====
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// reference copy of the kept csrs, stepped once per clock edge
logic        m_mie;
logic        m_mpie;
logic [31:0] m_mtvec;
logic [31:0] m_mepc;
logic [31:0] m_mcause;
logic [31:0] m_mtval;
logic [31:0] m_mscratch;
logic        m_meip;
logic        m_msip;
logic        m_mtip;
logic        m_meie;
logic        m_msie;
logic        m_mtie;
logic [63:0] m_cycle;
logic [63:0] m_mtimecmp;

task automatic model_reset();
    m_mie      = 1'b0;
    m_mpie     = 1'b0;
    m_mtvec    = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_mtval    = '0;
    m_mscratch = MSCRATCH_RESET;
    m_meip     = 1'b0;
    m_msip     = 1'b0;
    m_mtip     = 1'b0;
    m_meie     = 1'b1;     // external enabled out of reset
    m_msie     = 1'b0;
    m_mtie     = 1'b0;
    m_cycle    = '0;
    m_mtimecmp = MTIMECMP_RESET;
endtask

function automatic logic [31:0] model_read(input logic [11:0] addr);
    logic [31:0] v;
    v = '0;
    case (addr)
        12'hc00, 12'hc01, 12'hb00: v = m_cycle[31:0];
        12'hc80, 12'hc81, 12'hb80: v = m_cycle[63:32];
        12'h7c0: v = m_mtimecmp[31:0];
        12'h7c1: v = m_mtimecmp[63:32];
        12'hf14: v = HART_ID;
        12'h301: v = 32'h4000_0100;              // rv32i, mxl=1
        12'h300: begin
            v[3] = m_mie;
            v[7] = m_mpie;
        end
        12'h305: v = m_mtvec;
        12'h341: v = m_mepc;
        12'h342: v = m_mcause;
        12'h343: v = m_mtval;
        12'h340: v = m_mscratch;
        12'h344: begin
            v[3]  = m_msip;
            v[7]  = m_mtip;
            v[11] = m_meip;
        end
        12'h304: begin
            v[3]  = m_msie;
            v[7]  = m_mtie;
            v[11] = m_meie;
        end
        default: v = '0;                         // instret, ids, delegation
    endcase
    return v;
endfunction

// external over software over timer
function automatic logic [31:0] model_intr_op();
    if (m_mie && m_meie && m_meip)
        return 32'h8000_000b;
    if (m_mie && m_msie && m_msip)
        return 32'h8000_0003;
    if (m_mie && m_mtie && m_mtip)
        return 32'h8000_0007;
    return 32'h0;
endfunction

task automatic model_step(
    input logic                vld,
    input logic                rd_en,
    input logic [31:0]         inst,
    input logic [31:0]         rs1,
    input csr_port_pkg::trap_t trp,
    input logic                mret,
    input logic                meip_in,
    input logic                msip_in,
    input logic                rdy
);
    logic [31:0] old_v;
    logic [31:0] opnd;
    logic [31:0] wdata;
    logic [2:0]  f3;
    logic [11:0] addr;
    logic        we;
    logic        mtip_now;
    logic        hs;
    f3       = inst[14:12];
    addr     = inst[31:20];
    old_v    = model_read(addr);
    opnd     = f3[2] ? {27'd0, inst[19:15]} : rs1;
    case (f3)
        3'b001, 3'b101: wdata = opnd;
        3'b010, 3'b110: wdata = old_v | opnd;
        3'b011, 3'b111: wdata = old_v & ~opnd;
        default:        wdata = '0;
    endcase
    we       = vld && rd_en;
    mtip_now = m_cycle > m_mtimecmp;
    hs       = (model_intr_op() != 32'd0) && rdy;   // uses state before this edge

    if (trp.vld) begin
        m_mpie = m_mie;
        m_mie  = 1'b0;
    end else if (mret) begin
        m_mie  = m_mpie;
        m_mpie = 1'b1;
    end else if (we && addr == 12'h300) begin
        m_mie  = wdata[3];
        m_mpie = wdata[7];
    end

    if (we && addr == 12'h305) begin
        m_mtvec[31:2] = wdata[31:2];
        if (!wdata[1])
            m_mtvec[1:0] = wdata[1:0];
    end

    if (trp.vld) begin
        m_mepc   = trp.pc;
        m_mcause = trp.cause;
        m_mtval  = trp.cause[31] ? 32'd0 : trp.tval;
    end else begin
        if (we && addr == 12'h341)
            m_mepc = wdata;
        if (we && addr == 12'h342)
            m_mcause = wdata;
        if (we && addr == 12'h343)
            m_mtval = wdata;
    end

    if (we && addr == 12'h340)
        m_mscratch = wdata;
    if (we && addr == 12'h7c0)
        m_mtimecmp[31:0] = wdata;
    if (we && addr == 12'h7c1)
        m_mtimecmp[63:32] = wdata;
    m_cycle = m_cycle + 64'd1;

    if (hs) begin
        m_meip = 1'b0;
        m_msip = 1'b0;
        m_mtip = 1'b0;
    end else if (meip_in || msip_in || mtip_now) begin
        m_meip = meip_in;
        m_msip = msip_in && !meip_in;
        m_mtip = mtip_now && !msip_in && !meip_in;
    end else if (we && addr == 12'h344) begin
        m_meip = wdata[11];
        m_msip = wdata[3];
        m_mtip = wdata[7];
    end

    if (we && addr == 12'h304) begin
        m_meie = wdata[11];
        m_msie = wdata[3];
        m_mtie = wdata[7];
    end
endtask

`endif

// ==== dv/tb_csr_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_csr_unit;

    localparam int          CLK_PERIOD     = 100;
    localparam int          RESET_CYCLES   = 10;
    localparam int          NUM_CYCLES     = 4000;
    localparam int          NUM_ADDR       = 17;
    localparam logic [31:0] HART_ID        = 32'd5;
    localparam logic [63:0] MTIMECMP_RESET = 64'h0000_0001_4000_0200;
    localparam logic [31:0] MSCRATCH_RESET = 32'h1234_5678;

    // last entry is unmapped
    localparam logic [11:0] ADDR_LIST [NUM_ADDR] = '{
        12'h340, 12'h341, 12'h343, 12'h304, 12'h7c0, 12'h7c1, 12'h305, 12'h300,
        12'h342, 12'h344, 12'h301, 12'hf14, 12'h302, 12'hc02, 12'hb00, 12'hb80,
        12'h123
    };

    logic                      clk;
    logic                      rst_n;
    logic                      instruction_vld;
    csr_port_pkg::csr_inst_u   instruction_pld;
    logic [3:0]                instruction_idx;
    logic                      inst_rd_en;
    logic [31:0]               rs1_val;
    csr_port_pkg::trap_t       trap;
    logic                      mret_en;
    logic                      intr_meip_sync;
    logic                      intr_msip_sync;
    logic                      intr_rdy;
    logic                      intr_vld;
    logic [31:0]               intr_op;
    csr_port_pkg::reg_wb_t     reg_wb;
    logic [31:0]               csr_mtvec_val;
    logic [31:0]               csr_mepc_val;
    integer                    seed;

    `include "csr_model.svh"

    csr_unit #(
        .HART_ID        (HART_ID),
        .MTIMECMP_RESET (MTIMECMP_RESET),
        .MSCRATCH_RESET (MSCRATCH_RESET)
    ) u_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .instruction_vld (instruction_vld),
        .instruction_pld (instruction_pld),
        .instruction_idx (instruction_idx),
        .inst_rd_en      (inst_rd_en),
        .rs1_val         (rs1_val),
        .trap            (trap),
        .mret_en         (mret_en),
        .intr_meip_sync  (intr_meip_sync),
        .intr_msip_sync  (intr_msip_sync),
        .intr_rdy        (intr_rdy),
        .intr_vld        (intr_vld),
        .intr_op         (intr_op),
        .reg_wb          (reg_wb),
        .csr_mtvec_val   (csr_mtvec_val),
        .csr_mepc_val    (csr_mepc_val)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // bounded by the stimulus length plus some slack
    initial begin
        #((RESET_CYCLES + NUM_CYCLES + 20) * CLK_PERIOD);
        $display("Verification failed");
        $fatal(1, "watchdog timeout, stimulus loop did not finish");
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            $display("Verification failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic drive_random();
        logic [31:0]         r;
        logic [31:0]         r2;
        logic [31:0]         rs1;
        logic [11:0]         addr;
        int                  idx;
        csr_port_pkg::trap_t t;
        r    = $random(seed);
        r2   = $random(seed);
        rs1  = $random(seed);
        idx  = int'(r[7:0]) % NUM_ADDR;
        addr = ADDR_LIST[idx];
        if (r[30])
            rs1 = rs1 & 32'h0000_0fff;       // small values so mtimecmp can fall below cycle
        instruction_vld <= (r[13:11] != 3'd0);
        inst_rd_en      <= (r[15:14] != 2'd0);
        instruction_idx <= r[19:16];
        instruction_pld <= {addr, r[24:20], r[10:8], r[29:25], 7'h73};
        rs1_val         <= rs1;
        t.vld   = (r2[4:0] == 5'd0);
        t.pc    = $random(seed);
        t.cause = $random(seed);
        t.tval  = $random(seed);
        trap            <= t;
        mret_en         <= (r2[8:5] == 4'd0);
        intr_meip_sync  <= (r2[11:9] == 3'd0);
        intr_msip_sync  <= (r2[14:12] == 3'd0);
        intr_rdy        <= r2[15];
    endtask

    task automatic check_outputs();
        logic [31:0] w;
        logic [11:0] addr;
        w    = instruction_pld;
        addr = w[31:20];
        check_val($sformatf("reg_wb.val addr %h", addr), model_read(addr), reg_wb.val);
        check_val("reg_wb.wr_en", {31'd0, instruction_vld && inst_rd_en}, {31'd0, reg_wb.wr_en});
        check_val("reg_wb.commit", {31'd0, instruction_vld}, {31'd0, reg_wb.commit});
        check_val("reg_wb.index", {27'd0, w[11:7]}, {27'd0, reg_wb.index});
        check_val("reg_wb.inst_idx", {28'd0, instruction_idx}, {28'd0, reg_wb.inst_idx});
        check_val("intr_vld", {31'd0, model_intr_op() != 32'd0}, {31'd0, intr_vld});
        check_val("intr_op", model_intr_op(), intr_op);
        check_val("csr_mtvec_val", m_mtvec, csr_mtvec_val);
        check_val("csr_mepc_val", m_mepc, csr_mepc_val);
    endtask

    initial begin
        seed            = 32'hc4009281;
        rst_n           = 1'b0;
        instruction_vld = 1'b0;
        instruction_pld = '0;
        instruction_idx = '0;
        inst_rd_en      = 1'b0;
        rs1_val         = '0;
        trap            = '0;
        mret_en         = 1'b0;
        intr_meip_sync  = 1'b0;
        intr_msip_sync  = 1'b0;
        intr_rdy        = 1'b0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(posedge clk);
            // inputs seen at this edge are the ones driven one cycle ago
            model_step(instruction_vld, inst_rd_en, instruction_pld, rs1_val, trap,
                       mret_en, intr_meip_sync, intr_msip_sync, intr_rdy);
            drive_random();
            @(negedge clk);
            check_outputs();
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+dv
verilog/csr_arch_pkg.sv
verilog/csr_port_pkg.sv
verilog/csr_decode.sv
verilog/csr_trap_regs.sv
verilog/csr_timer.sv
verilog/csr_intr_ctrl.sv
verilog/csr_rmw.sv
verilog/csr_unit.sv
dv/tb_csr_unit.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f verilog.f --top-module tb_csr_unit -o sim_tb
	@out=$$(./obj_dir/sim_tb 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
